// File: src.f
+incdir+hdl
hdl/lb_pkg.sv
hdl/capture_pkg.sv
hdl/event_select.sv
hdl/capture_ctrl.sv
hdl/lb_regs.sv
hdl/mem_arbiter.sv
hdl/sample_ram.sv
hdl/logic_capture_top.sv
dv/tb_logic_capture.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_logic_capture -f src.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Test OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: dv/tb_logic_capture.sv
// one local-bus access in flight at a time; sample memory keeps its words between tests
`include "capture_macros.svh"

module tb_logic_capture;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RDY_LIMIT  = 64;
  localparam int POLL_LIMIT = 200;
  // state, host pending and stored count fields
  localparam lb_pkg::lb_data_t STATUS_MASK = 32'hFFFF_0013;
  localparam lb_pkg::lb_data_t ALL_BITS    = 32'hFFFF_FFFF;

  logic               clk_200m;
  logic               reset_200m;
  // index 0 is port A, index 7 is port H
  capture_pkg::port_t pins [8];
  logic               lb_wr;
  logic               lb_rd;
  lb_pkg::lb_addr_t   lb_addr;
  lb_pkg::lb_data_t   lb_wr_d;
  lb_pkg::lb_data_t   lb_rd_d;
  logic               lb_rd_rdy;

  // one entry per issued read, popped on lb_rd_rdy
  bit                 chk_q [$];
  lb_pkg::lb_data_t   exp_q [$];
  lb_pkg::lb_data_t   mask_q [$];
  string              what_q [$];

  int    err_cnt;
  int    check_cnt;
  int    pass_cnt;
  int    fail_cnt;
  int    test_num;
  int    err_at_start;
  string test_name;
  // set once a bounded wait has run out
  bit    timed_out;

  logic_capture_top dut0 (
    .clk_200m   (clk_200m),
    .reset_200m (reset_200m),
    .port_a     (pins[0]),
    .port_b     (pins[1]),
    .port_c     (pins[2]),
    .port_d     (pins[3]),
    .port_e     (pins[4]),
    .port_f     (pins[5]),
    .port_g     (pins[6]),
    .port_h     (pins[7]),
    .lb_wr      (lb_wr),
    .lb_rd      (lb_rd),
    .lb_addr    (lb_addr),
    .lb_wr_d    (lb_wr_d),
    .lb_rd_d    (lb_rd_d),
    .lb_rd_rdy  (lb_rd_rdy)
  );

  // 100 ns period
  initial begin
    clk_200m = 1'b0;
    forever begin
      #50 clk_200m = ~clk_200m;
    end
  end

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  // event word for static pins; the test counter source has no pin image
  function automatic capture_pkg::event_t expected_event(input capture_pkg::port_t p [8],
                                                         input logic [1:0] mode);
    capture_pkg::event_t ev;
    ev = '0;
    case (mode)
      `MODE_NIBBLES: begin
        // H shifted in first so it ends on top
        for (int i = 7; i >= 0; i--) begin
          ev = {ev[27:0], p[i][3:0]};
        end
      end
      `MODE_SIDE_AD: ev = {p[3], p[2], p[1], p[0]};
      `MODE_SIDE_EH: ev = {p[7], p[6], p[5], p[4]};
      default:       ev = '0;
    endcase
    return ev;
  endfunction

  // status with host pending clear
  function automatic lb_pkg::lb_data_t status_exp(input int count, input logic [1:0] st);
    return {count[15:0], 14'd0, st};
  endfunction

  // ----------------------------------------------------------------------
  // bus tasks, all start and end 1 ns after a rising edge
  // ----------------------------------------------------------------------
  task automatic stop_on_timeout(input string what);
    $display("timeout: %s", what);
    timed_out = 1'b1;
    // stimulus parks here for good
    wait (!timed_out);
  endtask

  task automatic bus_write(input logic [7:0] offs, input lb_pkg::lb_data_t data);
    @(posedge clk_200m);
    #1;
    lb_wr   = 1'b1;
    // upper address bits are not decoded
    lb_addr = {24'h400000, offs};
    lb_wr_d = data;
    @(posedge clk_200m);
    #1;
    lb_wr = 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] offs, input bit check, input lb_pkg::lb_data_t exp,
                          input lb_pkg::lb_data_t mask, input string what,
                          output lb_pkg::lb_data_t data);
    int n;
    chk_q.push_back(check);
    exp_q.push_back(exp);
    mask_q.push_back(mask);
    what_q.push_back(what);
    @(posedge clk_200m);
    #1;
    lb_rd   = 1'b1;
    lb_addr = {24'h400000, offs};
    @(posedge clk_200m);
    #1;
    lb_rd = 1'b0;
    n = 0;
    while (!lb_rd_rdy && n < RDY_LIMIT) begin
      @(posedge clk_200m);
      #1;
      n++;
    end
    if (!lb_rd_rdy) begin
      stop_on_timeout("no read ready pulse after a local-bus read");
    end
    data = lb_rd_d;
  endtask

  task automatic check_read(input logic [7:0] offs, input lb_pkg::lb_data_t exp,
                            input lb_pkg::lb_data_t mask, input string what);
    lb_pkg::lb_data_t unused;
    bus_read(offs, 1'b1, exp, mask, what, unused);
  endtask

  task automatic peek_reg(input logic [7:0] offs, output lb_pkg::lb_data_t data);
    bus_read(offs, 1'b0, '0, '0, "", data);
  endtask

  // posted write, then poll host pending
  task automatic mem_write(input capture_pkg::mem_addr_t addr, input lb_pkg::lb_data_t data);
    lb_pkg::lb_data_t st;
    int n;
    bus_write(`REG_MEM_ADDR, 32'(addr));
    bus_write(`REG_MEM_DATA, data);
    n = 0;
    st = 32'h1 << `STATUS_PEND_BIT;
    while (st[`STATUS_PEND_BIT] && n < POLL_LIMIT) begin
      peek_reg(`REG_STATUS, st);
      n++;
    end
    if (st[`STATUS_PEND_BIT]) begin
      stop_on_timeout("host pending never cleared after a memory write");
    end
  endtask

  task automatic mem_check(input capture_pkg::mem_addr_t addr, input lb_pkg::lb_data_t exp,
                           input lb_pkg::lb_data_t mask, input string what);
    bus_write(`REG_MEM_ADDR, 32'(addr));
    check_read(`REG_MEM_DATA, exp, mask, what);
  endtask

  task automatic mem_peek(input capture_pkg::mem_addr_t addr, output lb_pkg::lb_data_t data);
    bus_write(`REG_MEM_ADDR, 32'(addr));
    peek_reg(`REG_MEM_DATA, data);
  endtask

  task automatic wait_state(input capture_pkg::capture_state_t st, input string what);
    lb_pkg::lb_data_t s;
    int n;
    n = 0;
    peek_reg(`REG_STATUS, s);
    while (s[1:0] != st && n < POLL_LIMIT) begin
      peek_reg(`REG_STATUS, s);
      n++;
    end
    if (s[1:0] != st) begin
      stop_on_timeout(what);
    end
  endtask

  task automatic begin_test(input string name);
    test_num++;
    test_name    = name;
    err_at_start = err_cnt;
  endtask

  task automatic end_test();
    int n;
    n = 0;
    // let the checker catch up with the last read
    while (chk_q.size() != 0 && n < RDY_LIMIT) begin
      @(posedge clk_200m);
      #1;
      n++;
    end
    if (chk_q.size() != 0) begin
      stop_on_timeout("read checks still outstanding at the end of a test");
    end
    if (err_cnt == err_at_start) begin
      pass_cnt++;
      $display("test %0d %s: pass", test_num, test_name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: fail, %0d errors", test_num, test_name, err_cnt - err_at_start);
    end
  endtask

  // run ends here once any wait has run out
  initial begin
    wait (timed_out);
    $display("Test FAILED");
    $finish;
  end

  // ----------------------------------------------------------------------
  // compare process, mid cycle while lb_rd_rdy is stable
  // ----------------------------------------------------------------------
  always @(negedge clk_200m) begin
    bit               chk;
    lb_pkg::lb_data_t e;
    lb_pkg::lb_data_t m;
    string            w;
    if (lb_rd_rdy) begin
      if (chk_q.size() == 0) begin
        $display("read ready pulse seen with no read outstanding at %0t ns", $time);
        err_cnt++;
      end else begin
        chk = chk_q.pop_front();
        e   = exp_q.pop_front();
        m   = mask_q.pop_front();
        w   = what_q.pop_front();
        if (chk) begin
          check_cnt++;
          assert ((lb_rd_d & m) == (e & m)) else begin
            $display("** Error @ %0t ns: %s, got %h expected %h mask %h",
                     $time, w, lb_rd_d, e, m);
            err_cnt++;
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    capture_pkg::mem_addr_t addrs [8];
    capture_pkg::event_t    model [256];
    capture_pkg::port_t     trig_pins [8];
    lb_pkg::lb_data_t       v_mask;
    lb_pkg::lb_data_t       v_win;
    lb_pkg::lb_data_t       v_ctrl;
    lb_pkg::lb_data_t       first;
    lb_pkg::lb_data_t       word255;
    int unsigned            seed_init;
    int                     k;
    seed_init  = $urandom(32'h3a1a_494d);
    reset_200m = 1'b1;
    lb_wr      = 1'b0;
    lb_rd      = 1'b0;
    lb_addr    = '0;
    lb_wr_d    = '0;
    foreach (pins[j]) begin
      pins[j] = '0;
    end
    repeat (2) @(posedge clk_200m);
    #1;
    reset_200m = 1'b0;

    begin_test("reset status");
    check_read(`REG_STATUS, status_exp(0, 2'd0), STATUS_MASK, "status after reset");
    end_test();

    begin_test("register readback");
    for (int i = 0; i < 4; i++) begin
      v_mask = $urandom;
      v_win  = $urandom;
      // arm bit kept clear so the FSM stays idle
      v_ctrl = $urandom & ~(32'h1 << `CTRL_ARM_BIT);
      bus_write(`REG_TRIG_MASK, v_mask);
      bus_write(`REG_WINDOW, v_win);
      bus_write(`REG_CTRL, v_ctrl);
      check_read(`REG_TRIG_MASK, v_mask, ALL_BITS, "trigger mask readback");
      check_read(`REG_WINDOW, v_win, ALL_BITS, "window readback");
      check_read(`REG_CTRL, v_ctrl, 32'h3, "mode readback");
    end
    end_test();

    begin_test("host memory");
    for (int i = 0; i < 8; i++) begin
      addrs[i] = capture_pkg::mem_addr_t'($urandom);
      model[addrs[i]] = $urandom;
      mem_write(addrs[i], model[addrs[i]]);
    end
    for (int i = 0; i < 8; i++) begin
      mem_check(addrs[i], model[addrs[i]], ALL_BITS, "host memory readback");
    end
    end_test();

    begin_test("static pins");
    for (int m = 0; m < 3; m++) begin
      @(posedge clk_200m);
      #1;
      foreach (pins[j]) begin
        pins[j] = capture_pkg::port_t'($urandom);
      end
      bus_write(`REG_TRIG_MASK, '0);
      bus_write(`REG_WINDOW, 32'd20);
      bus_write(`REG_CTRL, 32'(m));
      // mode reaches the event word two cycles after the write
      repeat (3) @(posedge clk_200m);
      #1;
      bus_write(`REG_CTRL, 32'(m) | (32'h1 << `CTRL_ARM_BIT));
      wait_state(capture_pkg::st_done, "capture never reached done with static pins");
      check_read(`REG_STATUS, status_exp(1, 2'd3), STATUS_MASK, "static pins stored count");
      mem_check(0, expected_event(pins, 2'(m)), ALL_BITS, "static pins sample word");
    end
    end_test();

    begin_test("test counter");
    bus_write(`REG_WINDOW, 32'd30);
    bus_write(`REG_CTRL, 32'(`MODE_TEST_COUNT));
    repeat (3) @(posedge clk_200m);
    #1;
    bus_write(`REG_CTRL, 32'(`MODE_TEST_COUNT) | (32'h1 << `CTRL_ARM_BIT));
    wait_state(capture_pkg::st_done, "capture never reached done on the test counter");
    check_read(`REG_STATUS, status_exp(30, 2'd3), STATUS_MASK, "counter stored count");
    // counter phase is free, later words follow the first
    mem_peek(0, first);
    for (int i = 1; i < 30; i++) begin
      mem_check(capture_pkg::mem_addr_t'(i), first + 32'(i), ALL_BITS, "counter sample step");
    end
    end_test();

    begin_test("trigger");
    k = $urandom_range(7, 0);
    word255 = $urandom;
    mem_write(8'hFF, word255);
    @(posedge clk_200m);
    #1;
    foreach (pins[j]) begin
      pins[j] = capture_pkg::port_t'($urandom);
    end
    pins[0][k] = 1'b0;
    bus_write(`REG_TRIG_MASK, 32'h1 << k);
    bus_write(`REG_WINDOW, 32'd40);
    bus_write(`REG_CTRL, 32'(`MODE_SIDE_AD));
    repeat (3) @(posedge clk_200m);
    #1;
    bus_write(`REG_CTRL, 32'(`MODE_SIDE_AD) | (32'h1 << `CTRL_ARM_BIT));
    for (int i = 0; i < 3; i++) begin
      check_read(`REG_STATUS, status_exp(0, 2'd1), STATUS_MASK, "armed before trigger");
    end
    @(posedge clk_200m);
    #1;
    pins[0][k] = 1'b1;
    trig_pins  = pins;
    wait_state(capture_pkg::st_capture, "trigger bit raised but capture never started");
    bus_write(`REG_MEM_ADDR, 32'hFF);
    // capture write lands in the first cycle of the host request
    pins[1] = ~pins[1];
    @(posedge clk_200m);
    #1;
    check_read(`REG_MEM_DATA, word255, ALL_BITS, "host read during capture");
    wait_state(capture_pkg::st_done, "triggered capture never reached done");
    check_read(`REG_STATUS, status_exp(2, 2'd3), STATUS_MASK, "trigger stored count");
    mem_check(0, expected_event(trig_pins, `MODE_SIDE_AD), ALL_BITS, "trigger sample word");
    mem_check(1, expected_event(pins, `MODE_SIDE_AD), ALL_BITS, "changed sample word");
    end_test();

    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             test_num, pass_cnt, fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/logic_capture_top.sv
// single clock capture core; all host traffic on the plain-strobe local bus
module logic_capture_top (
  input  logic                clk_200m,
  input  logic                reset_200m,
  input  capture_pkg::port_t  port_a,
  input  capture_pkg::port_t  port_b,
  input  capture_pkg::port_t  port_c,
  input  capture_pkg::port_t  port_d,
  input  capture_pkg::port_t  port_e,
  input  capture_pkg::port_t  port_f,
  input  capture_pkg::port_t  port_g,
  input  capture_pkg::port_t  port_h,
  input  logic                lb_wr,
  input  logic                lb_rd,
  input  lb_pkg::lb_addr_t    lb_addr,
  input  lb_pkg::lb_data_t    lb_wr_d,
  output lb_pkg::lb_data_t    lb_rd_d,
  output logic                lb_rd_rdy
);

  // source select and capture control
  capture_pkg::event_mode_t    mode;
  capture_pkg::event_t         events;
  capture_pkg::event_t         trig_mask;
  lb_pkg::lb_data_t            window;
  logic                        arm;
  capture_pkg::capture_state_t state;
  capture_pkg::sample_count_t  stored_count;

  // capture write port
  logic                        cap_we;
  capture_pkg::mem_addr_t      cap_addr;
  capture_pkg::event_t         cap_data;

  // host memory request
  logic                        host_req;
  logic                        host_we;
  capture_pkg::mem_addr_t      host_addr;
  capture_pkg::event_t         host_wr_d;
  logic                        host_done;
  capture_pkg::event_t         host_rd_d;

  // memory port
  logic                        ram_we;
  capture_pkg::mem_addr_t      ram_addr;
  capture_pkg::event_t         ram_wr_d;
  capture_pkg::event_t         ram_rd_d;

  // ----------------------------------------------------------------------
  // capture path
  // ----------------------------------------------------------------------
  event_select u_event_select (
    .clk_200m   (clk_200m),
    .reset_200m (reset_200m),
    .port_a     (port_a),
    .port_b     (port_b),
    .port_c     (port_c),
    .port_d     (port_d),
    .port_e     (port_e),
    .port_f     (port_f),
    .port_g     (port_g),
    .port_h     (port_h),
    .mode       (mode),
    .events     (events)
  );

  capture_ctrl u_capture_ctrl (
    .clk_200m     (clk_200m),
    .reset_200m   (reset_200m),
    .events       (events),
    .arm          (arm),
    .trig_mask    (trig_mask),
    .window       (window),
    .cap_we       (cap_we),
    .cap_addr     (cap_addr),
    .cap_data     (cap_data),
    .state        (state),
    .stored_count (stored_count)
  );

  // ----------------------------------------------------------------------
  // host side and shared memory
  // ----------------------------------------------------------------------
  lb_regs u_lb_regs (
    .clk_200m     (clk_200m),
    .reset_200m   (reset_200m),
    .lb_wr        (lb_wr),
    .lb_rd        (lb_rd),
    .lb_addr      (lb_addr),
    .lb_wr_d      (lb_wr_d),
    .lb_rd_d      (lb_rd_d),
    .lb_rd_rdy    (lb_rd_rdy),
    .mode         (mode),
    .arm          (arm),
    .trig_mask    (trig_mask),
    .window       (window),
    .state        (state),
    .stored_count (stored_count),
    .host_req     (host_req),
    .host_we      (host_we),
    .host_addr    (host_addr),
    .host_wr_d    (host_wr_d),
    .host_done    (host_done),
    .host_rd_d    (host_rd_d)
  );

  mem_arbiter u_mem_arbiter (
    .clk_200m   (clk_200m),
    .reset_200m (reset_200m),
    .cap_we     (cap_we),
    .cap_addr   (cap_addr),
    .cap_data   (cap_data),
    .host_req   (host_req),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wr_d  (host_wr_d),
    .host_done  (host_done),
    .host_rd_d  (host_rd_d),
    .ram_we     (ram_we),
    .ram_addr   (ram_addr),
    .ram_wr_d   (ram_wr_d),
    .ram_rd_d   (ram_rd_d)
  );

  sample_ram u_sample_ram (
    .clk_200m (clk_200m),
    .ram_we   (ram_we),
    .ram_addr (ram_addr),
    .ram_wr_d (ram_wr_d),
    .ram_rd_d (ram_rd_d)
  );

endmodule

// File: hdl/sample_ram.sv
// single port, read-first, one cycle read latency; contents are undefined after power up
`include "capture_macros.svh"

module sample_ram (
  input  logic                    clk_200m,
  input  logic                    ram_we,
  input  capture_pkg::mem_addr_t  ram_addr,
  input  capture_pkg::event_t     ram_wr_d,
  output capture_pkg::event_t     ram_rd_d
);

  // 2^DEPTH_BITS event words
  capture_pkg::event_t mem [2**`DEPTH_BITS];

  always_ff @(posedge clk_200m) begin
    if (ram_we) begin
      mem[ram_addr] <= ram_wr_d;
    end
    // old word on a write cycle
    ram_rd_d <= mem[ram_addr];
  end

endmodule

// File: hdl/mem_arbiter.sv
// capture writes own the memory whenever cap_we is high; host waits for a free cycle
module mem_arbiter (
  input  logic                    clk_200m,
  input  logic                    reset_200m,
  input  logic                    cap_we,
  input  capture_pkg::mem_addr_t  cap_addr,
  input  capture_pkg::event_t     cap_data,
  input  logic                    host_req,
  input  logic                    host_we,
  input  capture_pkg::mem_addr_t  host_addr,
  input  capture_pkg::event_t     host_wr_d,
  output logic                    host_done,
  output capture_pkg::event_t     host_rd_d,
  output logic                    ram_we,
  output capture_pkg::mem_addr_t  ram_addr,
  output capture_pkg::event_t     ram_wr_d,
  input  capture_pkg::event_t     ram_rd_d
);

  logic host_grant;
  // granted host access waiting on read latency
  logic in_flight;

  // ----------------------------------------------------------------------
  // fixed priority, capture first
  // ----------------------------------------------------------------------
  // no regrant while the previous grant is still being answered
  assign host_grant = host_req && !cap_we && !in_flight;

  assign ram_we   = cap_we || (host_grant && host_we);
  assign ram_addr = cap_we ? cap_addr : host_addr;
  assign ram_wr_d = cap_we ? cap_data : host_wr_d;

  // ----------------------------------------------------------------------
  // grant tracking
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_200m) begin
    if (reset_200m) begin
      in_flight <= 1'b0;
    end else begin
      in_flight <= host_grant;
    end
  end

  // memory output is the word read in the grant cycle
  assign host_done = in_flight;
  assign host_rd_d = ram_rd_d;

endmodule

// File: hdl/lb_regs.sv
// one REG_MEM_DATA access at a time; poll host pending in REG_STATUS before the next one
`include "capture_macros.svh"

module lb_regs (
  input  logic                         clk_200m,
  input  logic                         reset_200m,
  input  logic                         lb_wr,
  input  logic                         lb_rd,
  input  lb_pkg::lb_addr_t             lb_addr,
  input  lb_pkg::lb_data_t             lb_wr_d,
  output lb_pkg::lb_data_t             lb_rd_d,
  output logic                         lb_rd_rdy,
  output capture_pkg::event_mode_t     mode,
  output logic                         arm,
  output capture_pkg::event_t          trig_mask,
  output lb_pkg::lb_data_t             window,
  input  capture_pkg::capture_state_t  state,
  input  capture_pkg::sample_count_t   stored_count,
  output logic                         host_req,
  output logic                         host_we,
  output capture_pkg::mem_addr_t       host_addr,
  output capture_pkg::event_t          host_wr_d,
  input  logic                         host_done,
  input  capture_pkg::event_t          host_rd_d
);

  capture_pkg::mem_addr_t mem_addr;
  lb_pkg::lb_data_t       reg_rd_mux;
  lb_pkg::lb_data_t       status_word;
  logic                   mem_sel;
  logic                   mem_start;
  logic                   rd_pend;
  logic                   rd_done;

  assign mem_sel   = (lb_addr[7:0] == `REG_MEM_DATA);
  assign mem_start = (lb_wr || lb_rd) && mem_sel;
  // memory read returns with the arbiter done pulse
  assign rd_done   = host_done && rd_pend;

  // ----------------------------------------------------------------------
  // readback mux
  // ----------------------------------------------------------------------
  always_comb begin
    status_word                   = '0;
    status_word[1:0]              = state;
    status_word[`STATUS_PEND_BIT] = host_req;
    status_word[31:16]            = 16'(stored_count);
    case (lb_addr[7:0])
      `REG_CTRL:      reg_rd_mux = lb_pkg::lb_data_t'(mode);
      `REG_TRIG_MASK: reg_rd_mux = lb_pkg::lb_data_t'(trig_mask);
      `REG_WINDOW:    reg_rd_mux = window;
      `REG_MEM_ADDR:  reg_rd_mux = lb_pkg::lb_data_t'(mem_addr);
      `REG_STATUS:    reg_rd_mux = status_word;
      default:        reg_rd_mux = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // control registers and host request
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_200m) begin
    if (reset_200m) begin
      mode      <= capture_pkg::mode_nibbles;
      arm       <= 1'b0;
      trig_mask <= '0;
      window    <= '0;
      mem_addr  <= '0;
      host_req  <= 1'b0;
      rd_pend   <= 1'b0;
      lb_rd_rdy <= 1'b0;
    end else begin
      arm       <= 1'b0;
      lb_rd_rdy <= rd_done || (lb_rd && !mem_sel);
      if (lb_wr) begin
        case (lb_addr[7:0])
          `REG_CTRL: begin
            mode <= capture_pkg::event_mode_t'(lb_wr_d[1:0]);
            arm  <= lb_wr_d[`CTRL_ARM_BIT];
          end
          `REG_TRIG_MASK: trig_mask <= capture_pkg::event_t'(lb_wr_d);
          `REG_WINDOW:    window    <= lb_wr_d;
          `REG_MEM_ADDR:  mem_addr  <= capture_pkg::mem_addr_t'(lb_wr_d);
          default:        ;
        endcase
      end
      // held until the arbiter answers
      if (host_done) begin
        host_req <= 1'b0;
        rd_pend  <= 1'b0;
      end
      if (mem_start) begin
        host_req <= 1'b1;
        rd_pend  <= lb_rd;
      end
    end
  end

  // request payload and read data
  always_ff @(posedge clk_200m) begin
    if (mem_start) begin
      host_we   <= lb_wr;
      host_addr <= mem_addr;
      host_wr_d <= capture_pkg::event_t'(lb_wr_d);
    end
    if (rd_done) begin
      lb_rd_d <= lb_pkg::lb_data_t'(host_rd_d);
    end else if (lb_rd && !mem_sel) begin
      lb_rd_d <= reg_rd_mux;
    end
  end

endmodule

// File: hdl/capture_ctrl.sv
// stores only changed event words; a window of 0 or 1 keeps just the trigger sample
`include "capture_macros.svh"

module capture_ctrl (
  input  logic                          clk_200m,
  input  logic                          reset_200m,
  input  capture_pkg::event_t           events,
  input  logic                          arm,
  input  capture_pkg::event_t           trig_mask,
  input  lb_pkg::lb_data_t              window,
  output logic                          cap_we,
  output capture_pkg::mem_addr_t        cap_addr,
  output capture_pkg::event_t           cap_data,
  output capture_pkg::capture_state_t   state,
  output capture_pkg::sample_count_t    stored_count
);

  capture_pkg::event_t        prev_events;
  capture_pkg::sample_count_t next_count;
  lb_pkg::lb_data_t           cyc_cnt;
  logic                       trig_hit;
  logic                       store_en;
  logic                       last_cycle;

  // zero mask triggers at once
  assign trig_hit   = (trig_mask == '0) || ((events & trig_mask) != '0);
  // trigger sample, then every change while capturing
  assign store_en   = ((state == capture_pkg::st_armed) && trig_hit) ||
                      ((state == capture_pkg::st_capture) && (events != prev_events));
  assign next_count = stored_count + store_en;
  // cyc_cnt already includes the trigger cycle
  assign last_cycle = (cyc_cnt + 1'b1) >= window;

  // ----------------------------------------------------------------------
  // capture FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_200m) begin
    if (reset_200m) begin
      state        <= capture_pkg::st_idle;
      stored_count <= '0;
      cyc_cnt      <= '0;
      cap_we       <= 1'b0;
    end else begin
      cap_we <= store_en;
      case (state)
        capture_pkg::st_armed: begin
          if (trig_hit) begin
            stored_count <= next_count;
            cyc_cnt      <= 1;
            state        <= (window > 1) ? capture_pkg::st_capture : capture_pkg::st_done;
          end
        end
        capture_pkg::st_capture: begin
          stored_count <= next_count;
          cyc_cnt      <= cyc_cnt + 1'b1;
          // window used up or memory full
          if (last_cycle || next_count[`DEPTH_BITS]) begin
            state <= capture_pkg::st_done;
          end
        end
        default: begin
          // arm only from idle or done
          if (arm) begin
            state        <= capture_pkg::st_armed;
            stored_count <= '0;
          end
        end
      endcase
    end
  end

  // previous word for change detect, write payload
  always_ff @(posedge clk_200m) begin
    prev_events <= events;
    if (store_en) begin
      cap_addr <= stored_count[`DEPTH_BITS-1:0];
      cap_data <= events;
    end
  end

endmodule

// File: hdl/event_select.sv
// pins are input only and sampled without synchronisers; events lag the pins by two cycles
module event_select (
  input  logic                 clk_200m,
  input  logic                 reset_200m,
  input  capture_pkg::port_t   port_a,
  input  capture_pkg::port_t   port_b,
  input  capture_pkg::port_t   port_c,
  input  capture_pkg::port_t   port_d,
  input  capture_pkg::port_t   port_e,
  input  capture_pkg::port_t   port_f,
  input  capture_pkg::port_t   port_g,
  input  capture_pkg::port_t   port_h,
  input  capture_pkg::event_mode_t mode,
  output capture_pkg::event_t  events
);

  // first stage, one flop per pin
  capture_pkg::port_t  pin_a;
  capture_pkg::port_t  pin_b;
  capture_pkg::port_t  pin_c;
  capture_pkg::port_t  pin_d;
  capture_pkg::port_t  pin_e;
  capture_pkg::port_t  pin_f;
  capture_pkg::port_t  pin_g;
  capture_pkg::port_t  pin_h;

  // free running internal source
  capture_pkg::event_t test_cnt;

  // ----------------------------------------------------------------------
  // pin registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_200m) begin
    pin_a <= port_a;
    pin_b <= port_b;
    pin_c <= port_c;
    pin_d <= port_d;
    pin_e <= port_e;
    pin_f <= port_f;
    pin_g <= port_g;
    pin_h <= port_h;
  end

  // ----------------------------------------------------------------------
  // test counter, zero out of reset then one per cycle
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_200m) begin
    if (reset_200m) begin
      test_cnt <= '0;
    end else begin
      test_cnt <= test_cnt + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // source select register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_200m) begin
    case (mode)
      // low nibble of every port, H on top
      capture_pkg::mode_nibbles: begin
        events <= {pin_h[3:0], pin_g[3:0], pin_f[3:0], pin_e[3:0],
                   pin_d[3:0], pin_c[3:0], pin_b[3:0], pin_a[3:0]};
      end
      capture_pkg::mode_side_ad: begin
        events <= {pin_d, pin_c, pin_b, pin_a};
      end
      capture_pkg::mode_side_eh: begin
        events <= {pin_h, pin_g, pin_f, pin_e};
      end
      default: begin
        events <= test_cnt;
      end
    endcase
  end

endmodule

// File: hdl/capture_pkg.sv
// event, sample-memory and FSM types; codes must match REG_CTRL and REG_STATUS fields
`include "capture_macros.svh"

package capture_pkg;

  // ----------------------------------------------------------------------
  // data words
  // ----------------------------------------------------------------------
  typedef logic [`EVENT_BITS-1:0] event_t;
  typedef logic [`PORT_BITS-1:0]  port_t;

  // sample memory address and fill count
  typedef logic [`DEPTH_BITS-1:0] mem_addr_t;
  // one extra bit so a full memory is visible
  typedef logic [`DEPTH_BITS:0]   sample_count_t;

  // ----------------------------------------------------------------------
  // encodings
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    mode_nibbles    = `MODE_NIBBLES,
    mode_side_ad    = `MODE_SIDE_AD,
    mode_side_eh    = `MODE_SIDE_EH,
    mode_test_count = `MODE_TEST_COUNT
  } event_mode_t;

  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_armed   = 2'd1,
    st_capture = 2'd2,
    st_done    = 2'd3
  } capture_state_t;

endpackage

// File: hdl/lb_pkg.sv
// local-bus word types; widths come from capture_macros.svh
`include "capture_macros.svh"

package lb_pkg;

  // ----------------------------------------------------------------------
  // local-bus words
  // ----------------------------------------------------------------------

  // byte address from the host, only the low 8 bits are decoded
  typedef logic [`LB_ADDR_BITS-1:0] lb_addr_t;

  // write and readback data
  typedef logic [`LB_DATA_BITS-1:0] lb_data_t;

endpackage

// File: hdl/capture_macros.svh
// sizes and register map for the capture core; EVENT_BITS must equal four PORT_BITS and LB_DATA_BITS
`ifndef CAPTURE_MACROS_SVH
`define CAPTURE_MACROS_SVH

// ----------------------------------------------------------------------
// widths
// ----------------------------------------------------------------------
`define EVENT_BITS    32
`define PORT_BITS     8
// 256 sample words
`define DEPTH_BITS    8
`define LB_ADDR_BITS  32
`define LB_DATA_BITS  32

// ----------------------------------------------------------------------
// register offsets, low 8 address bits
// ----------------------------------------------------------------------
`define REG_CTRL      8'h90
`define REG_TRIG_MASK 8'h94
`define REG_WINDOW    8'h98
`define REG_MEM_ADDR  8'h9C
`define REG_MEM_DATA  8'hA0
`define REG_STATUS    8'hA4

// arm strobe in REG_CTRL, host pending in REG_STATUS
`define CTRL_ARM_BIT    4
`define STATUS_PEND_BIT 4

// event source codes in REG_CTRL bits 1..0
`define MODE_NIBBLES    2'd0
`define MODE_SIDE_AD    2'd1
`define MODE_SIDE_EH    2'd2
`define MODE_TEST_COUNT 2'd3

`endif
